/* common/gfx_bus_pkg.sv */
/*
 32-bit bus with byte selects and a small register window.
 Only full-word accesses are accepted, reads ack after a fixed delay.
*/
package gfx_bus_pkg;

  // data lane width
  localparam int DATA_W = 32;

  // byte offset within the register window
  localparam int ADR_W = 8;

  // one select bit per data byte
  localparam int SEL_W = DATA_W / 8;

  // cycles from the start of a read access to its ack, at least 2
  localparam int READ_ACK_DELAY = 3;

endpackage

/* common/gfx_reg_pkg.sv */
/*
 Register map and command-path constants of the graphics front end.
 Register offsets are byte addresses, word aligned.
 Needs gfx_bus_pkg compiled first.
*/
package gfx_reg_pkg;

  // register byte offsets
  typedef enum logic [gfx_bus_pkg::ADR_W-1:0] {
    REG_CONTROL       = 8'h00,
    REG_STATUS        = 8'h04,
    REG_TARGET_BASE   = 8'h08,
    REG_TARGET_SIZE_X = 8'h0c,
    REG_TARGET_SIZE_Y = 8'h10,
    REG_DEST_X        = 8'h14,
    REG_DEST_Y        = 8'h18,
    REG_COLOR0        = 8'h1c,
    REG_ALPHA         = 8'h20
  } gfx_reg_e;

  // control register, enables and depth field
  localparam int CTRL_DEPTH = 0;
  localparam int CTRL_BLEND = 2;
  localparam int CTRL_CLIP  = 3;

  // control register, self-clearing draw triggers
  localparam int CTRL_RECT = 8;
  localparam int CTRL_LINE = 9;
  localparam int CTRL_TRI  = 10;

  // status register layout
  localparam int STAT_BUSY      = 0;
  localparam int STAT_COUNT_LSB = 16;

  localparam logic [gfx_bus_pkg::DATA_W-1:0] ALPHA_RESET = '1;

  // command queue holds 2**FIFO_DEPTH_LOG2 entries
  localparam int FIFO_DEPTH_LOG2 = 4;

  typedef enum logic {
    SEQ_WAIT,
    SEQ_BUSY
  } seq_state_e;

endpackage

/* source/wb_bus_port.sv */
/*
 Slave side of the bus. Master must drop stb after ack.
 Partial byte selects get err and are never queued.
*/
`timescale 1ns/10ps

module wb_bus_port (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           cs_i,
  input  logic                           cyc_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [gfx_bus_pkg::SEL_W-1:0]  sel_i,
  input  logic [gfx_bus_pkg::ADR_W-1:0]  adr_i,
  input  logic [gfx_bus_pkg::DATA_W-1:0] dat_i,
  input  logic                           enq_ready_i,
  input  logic [gfx_bus_pkg::DATA_W-1:0] rd_data_i,
  output logic                           ack_o,
  output logic                           err_o,
  output logic [gfx_bus_pkg::DATA_W-1:0] dat_o,
  output logic                           enq_valid_o,
  output logic [gfx_bus_pkg::ADR_W-1:0]  enq_adr_o,
  output logic [gfx_bus_pkg::DATA_W-1:0] enq_data_o,
  output logic [gfx_bus_pkg::ADR_W-1:0]  rd_adr_o
);

  logic access;
  logic full_sel;
  logic read_acc;
  logic wr_ack;
  logic rd_ack;
  logic [gfx_bus_pkg::READ_ACK_DELAY-1:0] rd_pipe_q;

  assign access   = cs_i & cyc_i & stb_i;
  assign full_sel = &sel_i;
  assign read_acc = access & ~we_i & full_sel;

  // full-word writes go to the queue, ack only when it takes the entry
  assign enq_valid_o = access & we_i & full_sel;
  assign enq_adr_o   = adr_i;
  assign enq_data_o  = dat_i;
  assign wr_ack      = enq_valid_o & enq_ready_i;

  // read ack once the access has been held for the full delay
  assign rd_ack = read_acc & rd_pipe_q[gfx_bus_pkg::READ_ACK_DELAY-1];

  assign ack_o    = wr_ack | rd_ack;
  assign err_o    = access & ~full_sel;
  assign rd_adr_o = adr_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      rd_pipe_q <= '0;
      dat_o     <= '0;
    end
    else
    begin
      dat_o <= rd_data_i;
      if (read_acc)
        rd_pipe_q <= {rd_pipe_q[gfx_bus_pkg::READ_ACK_DELAY-2:0], 1'b1};
      else
        rd_pipe_q <= '0;
    end
  end

endmodule

/* source/cmd_fifo.sv */
/*
 Circular command queue of address/data pairs.
 Head entry is shown whenever the queue is not empty.
*/
`timescale 1ns/10ps

module cmd_fifo (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  enq_valid_i,
  input  logic [gfx_bus_pkg::ADR_W-1:0]         enq_adr_i,
  input  logic [gfx_bus_pkg::DATA_W-1:0]        enq_data_i,
  input  logic                                  deq_ready_i,
  output logic                                  enq_ready_o,
  output logic                                  deq_valid_o,
  output logic [gfx_bus_pkg::ADR_W-1:0]         deq_adr_o,
  output logic [gfx_bus_pkg::DATA_W-1:0]        deq_data_o,
  output logic [gfx_reg_pkg::FIFO_DEPTH_LOG2:0] count_o
);

  logic [gfx_bus_pkg::ADR_W-1:0]  adr_mem  [2**gfx_reg_pkg::FIFO_DEPTH_LOG2];
  logic [gfx_bus_pkg::DATA_W-1:0] data_mem [2**gfx_reg_pkg::FIFO_DEPTH_LOG2];
  logic [gfx_reg_pkg::FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [gfx_reg_pkg::FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic push;
  logic pop;

  // full when the count reaches the depth
  assign enq_ready_o = ~count_o[gfx_reg_pkg::FIFO_DEPTH_LOG2];
  assign deq_valid_o = (count_o != '0);
  assign push        = enq_valid_i & enq_ready_o;
  assign pop         = deq_ready_i & deq_valid_o;

  assign deq_adr_o  = adr_mem[rd_ptr];
  assign deq_data_o = data_mem[rd_ptr];

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      adr_mem[wr_ptr]  <= enq_adr_i;
      data_mem[wr_ptr] <= enq_data_i;
    end
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push & ~pop)
        count_o <= count_o + 1'b1;
      else if (pop & ~push)
        count_o <= count_o - 1'b1;
    end
  end

endmodule

/* source/cmd_sequencer.sv */
/*
 Paces queue drain into the register file, one entry every two cycles
 at most. Stays busy after a draw trigger until the pipeline acks.
*/
`timescale 1ns/10ps

module cmd_sequencer (
  input  logic clk_i,
  input  logic rst_i,
  input  logic q_valid_i,
  input  logic trigger_i,
  input  logic pipeline_ack_i,
  input  logic writer_err_i,
  input  logic reader_err_i,
  output logic q_ready_o,
  output logic busy_o,
  output logic irq_o
);

  gfx_reg_pkg::seq_state_e state_q;
  logic applied_q;

  // hold off one cycle after an apply so a trigger shows before the next entry
  assign q_ready_o = (state_q == gfx_reg_pkg::SEQ_WAIT) & ~trigger_i & ~applied_q;
  assign busy_o    = (state_q == gfx_reg_pkg::SEQ_BUSY);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q   <= gfx_reg_pkg::SEQ_WAIT;
      applied_q <= 1'b0;
    end
    else
    begin
      applied_q <= q_valid_i & q_ready_o;
      case (state_q)
        gfx_reg_pkg::SEQ_WAIT:
          if (trigger_i)
            state_q <= gfx_reg_pkg::SEQ_BUSY;
        gfx_reg_pkg::SEQ_BUSY:
          if (pipeline_ack_i)
            state_q <= gfx_reg_pkg::SEQ_WAIT;
        default:
          state_q <= gfx_reg_pkg::SEQ_WAIT;
      endcase
    end
  end

  // error interrupt, one cycle behind its sources
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      irq_o <= 1'b0;
    else
      irq_o <= writer_err_i | reader_err_i;
  end

endmodule

/* regfile/gfx_reg_file.sv */
/*
 Register storage with field outputs and the read mux.
 Draw triggers last one cycle. Status is read-only, unmapped offsets read 0.
*/
`timescale 1ns/10ps

module gfx_reg_file (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  apply_i,
  input  logic [gfx_bus_pkg::ADR_W-1:0]         apply_adr_i,
  input  logic [gfx_bus_pkg::DATA_W-1:0]        apply_data_i,
  input  logic [gfx_bus_pkg::ADR_W-1:0]         rd_adr_i,
  input  logic                                  busy_i,
  input  logic [gfx_reg_pkg::FIFO_DEPTH_LOG2:0] count_i,
  output logic                                  trigger_o,
  output logic [gfx_bus_pkg::DATA_W-1:0]        rd_data_o,
  output logic                                  rect_write_o,
  output logic                                  line_write_o,
  output logic                                  triangle_write_o,
  output logic                                  blending_enable_o,
  output logic                                  clipping_enable_o,
  output logic [1:0]                            color_depth_o,
  output logic [28:0]                           target_base_o,
  output logic [15:0]                           target_size_x_o,
  output logic [15:0]                           target_size_y_o,
  output logic [31:0]                           dest_x_o,
  output logic [31:0]                           dest_y_o,
  output logic [31:0]                           color0_o,
  output logic [7:0]                            global_alpha_o
);

  logic [gfx_bus_pkg::DATA_W-1:0] control_reg;
  logic [gfx_bus_pkg::DATA_W-1:0] target_base_reg;
  logic [gfx_bus_pkg::DATA_W-1:0] target_size_x_reg;
  logic [gfx_bus_pkg::DATA_W-1:0] target_size_y_reg;
  logic [gfx_bus_pkg::DATA_W-1:0] dest_x_reg;
  logic [gfx_bus_pkg::DATA_W-1:0] dest_y_reg;
  logic [gfx_bus_pkg::DATA_W-1:0] color0_reg;
  logic [gfx_bus_pkg::DATA_W-1:0] alpha_reg;
  logic [gfx_bus_pkg::DATA_W-1:0] status_word;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      control_reg       <= '0;
      target_base_reg   <= '0;
      target_size_x_reg <= '0;
      target_size_y_reg <= '0;
      dest_x_reg        <= '0;
      dest_y_reg        <= '0;
      color0_reg        <= '0;
      alpha_reg         <= gfx_reg_pkg::ALPHA_RESET;
    end
    else if (apply_i)
    begin
      case (apply_adr_i)
        gfx_reg_pkg::REG_CONTROL:       control_reg       <= apply_data_i;
        gfx_reg_pkg::REG_TARGET_BASE:   target_base_reg   <= apply_data_i;
        gfx_reg_pkg::REG_TARGET_SIZE_X: target_size_x_reg <= apply_data_i;
        gfx_reg_pkg::REG_TARGET_SIZE_Y: target_size_y_reg <= apply_data_i;
        gfx_reg_pkg::REG_DEST_X:        dest_x_reg        <= apply_data_i;
        gfx_reg_pkg::REG_DEST_Y:        dest_y_reg        <= apply_data_i;
        gfx_reg_pkg::REG_COLOR0:        color0_reg        <= apply_data_i;
        gfx_reg_pkg::REG_ALPHA:         alpha_reg         <= apply_data_i;
        default:
        begin
          // status and unmapped offsets take no write
        end
      endcase
    end
    else
    begin
      // triggers drop in the first cycle without an apply
      control_reg[gfx_reg_pkg::CTRL_RECT] <= 1'b0;
      control_reg[gfx_reg_pkg::CTRL_LINE] <= 1'b0;
      control_reg[gfx_reg_pkg::CTRL_TRI]  <= 1'b0;
    end
  end

  // control fields
  assign rect_write_o      = control_reg[gfx_reg_pkg::CTRL_RECT];
  assign line_write_o      = control_reg[gfx_reg_pkg::CTRL_LINE];
  assign triangle_write_o  = control_reg[gfx_reg_pkg::CTRL_TRI];
  assign blending_enable_o = control_reg[gfx_reg_pkg::CTRL_BLEND];
  assign clipping_enable_o = control_reg[gfx_reg_pkg::CTRL_CLIP];
  assign color_depth_o     = control_reg[gfx_reg_pkg::CTRL_DEPTH+1:gfx_reg_pkg::CTRL_DEPTH];
  assign trigger_o         = rect_write_o | line_write_o | triangle_write_o;

  // target base is 8-byte aligned
  assign target_base_o   = target_base_reg[31:3];
  assign target_size_x_o = target_size_x_reg[15:0];
  assign target_size_y_o = target_size_y_reg[15:0];
  assign dest_x_o        = dest_x_reg;
  assign dest_y_o        = dest_y_reg;
  assign color0_o        = color0_reg;
  assign global_alpha_o  = alpha_reg[7:0];

  always_comb
  begin
    status_word = '0;
    status_word[gfx_reg_pkg::STAT_BUSY] = busy_i;
    status_word[gfx_reg_pkg::STAT_COUNT_LSB +: gfx_reg_pkg::FIFO_DEPTH_LOG2+1] = count_i;
  end

  // current register values, pending queue entries are not visible
  always_comb
  begin
    case (rd_adr_i)
      gfx_reg_pkg::REG_CONTROL:       rd_data_o = control_reg;
      gfx_reg_pkg::REG_STATUS:        rd_data_o = status_word;
      gfx_reg_pkg::REG_TARGET_BASE:   rd_data_o = target_base_reg;
      gfx_reg_pkg::REG_TARGET_SIZE_X: rd_data_o = target_size_x_reg;
      gfx_reg_pkg::REG_TARGET_SIZE_Y: rd_data_o = target_size_y_reg;
      gfx_reg_pkg::REG_DEST_X:        rd_data_o = dest_x_reg;
      gfx_reg_pkg::REG_DEST_Y:        rd_data_o = dest_y_reg;
      gfx_reg_pkg::REG_COLOR0:        rd_data_o = color0_reg;
      gfx_reg_pkg::REG_ALPHA:         rd_data_o = alpha_reg;
      default:                        rd_data_o = '0;
    endcase
  end

endmodule

/* source/gfx_wbs_top.sv */
/*
 Command front end. Writes are queued and applied in order,
 reads see the register file directly and may bypass pending writes.
*/
`timescale 1ns/10ps

module gfx_wbs_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                cs_i,
  input  logic                                cyc_i,
  input  logic                                stb_i,
  input  logic                                we_i,
  input  logic [gfx_bus_pkg::SEL_W-1:0]       sel_i,
  input  logic [gfx_bus_pkg::ADR_W-1:0]       adr_i,
  input  logic [gfx_bus_pkg::DATA_W-1:0]      dat_i,
  input  logic                                pipeline_ack_i,
  input  logic                                writer_err_i,
  input  logic                                reader_err_i,
  output logic                                ack_o,
  output logic                                err_o,
  output logic [gfx_bus_pkg::DATA_W-1:0]      dat_o,
  output logic                                irq_o,
  output logic                                rect_write_o,
  output logic                                line_write_o,
  output logic                                triangle_write_o,
  output logic                                blending_enable_o,
  output logic                                clipping_enable_o,
  output logic [1:0]                          color_depth_o,
  output logic [28:0]                         target_base_o,
  output logic [15:0]                         target_size_x_o,
  output logic [15:0]                         target_size_y_o,
  output logic [31:0]                         dest_x_o,
  output logic [31:0]                         dest_y_o,
  output logic [31:0]                         color0_o,
  output logic [7:0]                          global_alpha_o
);

  logic                                  enq_valid;
  logic                                  enq_ready;
  logic [gfx_bus_pkg::ADR_W-1:0]         enq_adr;
  logic [gfx_bus_pkg::DATA_W-1:0]        enq_data;
  logic                                  q_valid;
  logic                                  q_ready;
  logic [gfx_bus_pkg::ADR_W-1:0]         q_adr;
  logic [gfx_bus_pkg::DATA_W-1:0]        q_data;
  logic [gfx_reg_pkg::FIFO_DEPTH_LOG2:0] q_count;
  logic [gfx_bus_pkg::ADR_W-1:0]         rd_adr;
  logic [gfx_bus_pkg::DATA_W-1:0]        rd_data;
  logic                                  apply;
  logic                                  trigger;
  logic                                  busy;

  // queue head taken by the register file
  assign apply = q_valid & q_ready;

  wb_bus_port u_bus_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cs_i        (cs_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .sel_i       (sel_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .enq_ready_i (enq_ready),
    .rd_data_i   (rd_data),
    .ack_o       (ack_o),
    .err_o       (err_o),
    .dat_o       (dat_o),
    .enq_valid_o (enq_valid),
    .enq_adr_o   (enq_adr),
    .enq_data_o  (enq_data),
    .rd_adr_o    (rd_adr)
  );

  cmd_fifo u_cmd_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .enq_valid_i (enq_valid),
    .enq_adr_i   (enq_adr),
    .enq_data_i  (enq_data),
    .deq_ready_i (q_ready),
    .enq_ready_o (enq_ready),
    .deq_valid_o (q_valid),
    .deq_adr_o   (q_adr),
    .deq_data_o  (q_data),
    .count_o     (q_count)
  );

  cmd_sequencer u_sequencer (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .q_valid_i      (q_valid),
    .trigger_i      (trigger),
    .pipeline_ack_i (pipeline_ack_i),
    .writer_err_i   (writer_err_i),
    .reader_err_i   (reader_err_i),
    .q_ready_o      (q_ready),
    .busy_o         (busy),
    .irq_o          (irq_o)
  );

  gfx_reg_file u_reg_file (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .apply_i           (apply),
    .apply_adr_i       (q_adr),
    .apply_data_i      (q_data),
    .rd_adr_i          (rd_adr),
    .busy_i            (busy),
    .count_i           (q_count),
    .trigger_o         (trigger),
    .rd_data_o         (rd_data),
    .rect_write_o      (rect_write_o),
    .line_write_o      (line_write_o),
    .triangle_write_o  (triangle_write_o),
    .blending_enable_o (blending_enable_o),
    .clipping_enable_o (clipping_enable_o),
    .color_depth_o     (color_depth_o),
    .target_base_o     (target_base_o),
    .target_size_x_o   (target_size_x_o),
    .target_size_y_o   (target_size_y_o),
    .dest_x_o          (dest_x_o),
    .dest_y_o          (dest_y_o),
    .color0_o          (color0_o),
    .global_alpha_o    (global_alpha_o)
  );

endmodule

/* sim/tb_bus_tasks.svh */
/*
 Bus master tasks for the graphics front end testbench.
 One access at a time; stb drops on the falling edge after ack or err.
*/

// any mismatch ends the run at once
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual)
  begin
    $display("FAIL %s expected %h actual %h", name, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "value mismatch");
  end
endtask

// drives one access and waits for ack or err
task automatic bus_access(input logic we, input logic [gfx_bus_pkg::SEL_W-1:0] sel,
                          input logic [gfx_bus_pkg::ADR_W-1:0] adr,
                          input logic [gfx_bus_pkg::DATA_W-1:0] wdata,
                          output logic [gfx_bus_pkg::DATA_W-1:0] rdata,
                          output logic got_ack, output logic got_err);
  @(negedge clk_i);
  cs_i  = 1'b1;
  cyc_i = 1'b1;
  stb_i = 1'b1;
  we_i  = we;
  sel_i = sel;
  adr_i = adr;
  dat_i = wdata;
  @(posedge clk_i);
  while (ack_o !== 1'b1 && err_o !== 1'b1)
    @(posedge clk_i);
  rdata   = dat_o;
  got_ack = ack_o;
  got_err = err_o;
  @(negedge clk_i);
  cs_i  = 1'b0;
  cyc_i = 1'b0;
  stb_i = 1'b0;
  we_i  = 1'b0;
endtask

task automatic bus_write(input logic [gfx_bus_pkg::ADR_W-1:0] adr,
                         input logic [gfx_bus_pkg::DATA_W-1:0] data);
  logic [gfx_bus_pkg::DATA_W-1:0] unused;
  logic got_ack;
  logic got_err;
  bus_access(1'b1, '1, adr, data, unused, got_ack, got_err);
  check_value($sformatf("write %h ack", adr), 1, got_ack);
endtask

task automatic bus_read(input logic [gfx_bus_pkg::ADR_W-1:0] adr,
                        output logic [gfx_bus_pkg::DATA_W-1:0] data);
  logic got_ack;
  logic got_err;
  bus_access(1'b0, '1, adr, '0, data, got_ack, got_err);
  check_value($sformatf("read %h err", adr), 0, got_err);
endtask

// polls status until every queued write has been applied
task automatic wait_queue_empty();
  logic [gfx_bus_pkg::DATA_W-1:0] status;
  bus_read(gfx_reg_pkg::REG_STATUS, status);
  while (status[gfx_reg_pkg::STAT_COUNT_LSB +: gfx_reg_pkg::FIFO_DEPTH_LOG2+1] != 0)
    bus_read(gfx_reg_pkg::REG_STATUS, status);
endtask

/* sim/tb_gfx_wbs.sv */
/*
 Testbench for the graphics command front end.
 Steps come from a table built at time zero with a fixed seed.
 A cycle limit derived from the table length stops a hung run.
*/
`timescale 1ns/10ps

module tb_gfx_wbs;

  localparam int MAX_STEPS = 128;
  localparam logic [31:0] TRIG_MASK = (32'd1 << gfx_reg_pkg::CTRL_RECT) |
                                      (32'd1 << gfx_reg_pkg::CTRL_LINE) |
                                      (32'd1 << gfx_reg_pkg::CTRL_TRI);
  localparam logic [31:0] STAT_ONE_BUSY = (32'd1 << gfx_reg_pkg::STAT_COUNT_LSB) |
                                          (32'd1 << gfx_reg_pkg::STAT_BUSY);

  typedef enum {
    OP_WR, OP_RD, OP_PART, OP_DRAIN, OP_ACK, OP_TRIG, OP_FIELDS, OP_STALL, OP_ERR
  } op_e;

  logic                           clk_i;
  logic                           rst_i;
  logic                           cs_i;
  logic                           cyc_i;
  logic                           stb_i;
  logic                           we_i;
  logic [gfx_bus_pkg::SEL_W-1:0]  sel_i;
  logic [gfx_bus_pkg::ADR_W-1:0]  adr_i;
  logic [gfx_bus_pkg::DATA_W-1:0] dat_i;
  logic                           pipeline_ack_i;
  logic                           writer_err_i;
  logic                           reader_err_i;
  logic                           ack_o;
  logic                           err_o;
  logic [gfx_bus_pkg::DATA_W-1:0] dat_o;
  logic                           irq_o;
  logic                           rect_write_o;
  logic                           line_write_o;
  logic                           triangle_write_o;
  logic                           blending_enable_o;
  logic                           clipping_enable_o;
  logic [1:0]                     color_depth_o;
  logic [28:0]                    target_base_o;
  logic [15:0]                    target_size_x_o;
  logic [15:0]                    target_size_y_o;
  logic [31:0]                    dest_x_o;
  logic [31:0]                    dest_y_o;
  logic [31:0]                    color0_o;
  logic [7:0]                     global_alpha_o;

  op_e         op_tab  [0:MAX_STEPS-1];
  logic [7:0]  adr_tab [0:MAX_STEPS-1];
  logic [31:0] dat_tab [0:MAX_STEPS-1];
  logic [31:0] exp_tab [0:MAX_STEPS-1];
  logic [31:0] shadow  [0:15];
  int          ntab = 0;
  int          trig_pulses [0:2] = '{0, 0, 0};
  int          cycles = 0;
  int          limit = 0;
  integer      seed;

  `include "tb_bus_tasks.svh"

  gfx_wbs_top uut (.*);

  always #4 clk_i = ~clk_i;

  // counts high cycles of each draw trigger
  always @(posedge clk_i)
  begin
    if (rect_write_o === 1'b1)
      trig_pulses[0] = trig_pulses[0] + 1;
    if (line_write_o === 1'b1)
      trig_pulses[1] = trig_pulses[1] + 1;
    if (triangle_write_o === 1'b1)
      trig_pulses[2] = trig_pulses[2] + 1;
  end

  always @(posedge clk_i)
  begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit)
    begin
      $display("timeout: no bus response within %0d cycles, the run hung", limit);
      $display("TEST FAILED");
      $fatal(1, "simulation hung");
    end
  end

  task automatic add_step(input op_e op, input logic [7:0] adr, input logic [31:0] data,
                          input logic [31:0] expected);
    op_tab[ntab]  = op;
    adr_tab[ntab] = adr;
    dat_tab[ntab] = data;
    exp_tab[ntab] = expected;
    ntab = ntab + 1;
  endtask

  // model holds what a read of each register word must return
  task automatic build_table();
    logic [31:0] model [0:15];
    logic [31:0] d;
    logic [31:0] c;
    int k;
    for (k = 0; k < 16; k++)
      model[k] = '0;
    model[8] = gfx_reg_pkg::ALPHA_RESET;
    for (k = 0; k <= 8; k++)
      add_step(OP_RD, {k[5:0], 2'b00}, 0, model[k]);
    for (k = 0; k <= 8; k++)
    begin
      if (k == 1)
        continue;
      d = $random(seed);
      if (k == 0)
        d = d & ~TRIG_MASK;
      add_step(OP_WR, {k[5:0], 2'b00}, d, 0);
      model[k] = d;
    end
    add_step(OP_DRAIN, 0, 0, 0);
    for (k = 0; k <= 8; k++)
      add_step(OP_RD, {k[5:0], 2'b00}, 0, model[k]);
    add_step(OP_FIELDS, 0, 0, 0);
    add_step(OP_PART, gfx_reg_pkg::REG_DEST_X, $random(seed), 0);
    add_step(OP_RD, gfx_reg_pkg::REG_DEST_X, 0, model[5]);
    for (k = 0; k < 3; k++)
    begin
      d = ($random(seed) & ~TRIG_MASK) | (32'd1 << (gfx_reg_pkg::CTRL_RECT + k));
      c = $random(seed);
      add_step(OP_WR, gfx_reg_pkg::REG_CONTROL, d, 0);
      add_step(OP_WR, gfx_reg_pkg::REG_COLOR0, c, 0);
      add_step(OP_RD, gfx_reg_pkg::REG_STATUS, 0, STAT_ONE_BUSY);
      add_step(OP_RD, gfx_reg_pkg::REG_COLOR0, 0, model[7]);
      add_step(OP_TRIG, {6'd0, k[1:0]}, 0, 1);
      add_step(OP_ACK, 0, 0, 0);
      add_step(OP_DRAIN, 0, 0, 0);
      model[0] = d & ~TRIG_MASK;
      model[7] = c;
      add_step(OP_RD, gfx_reg_pkg::REG_COLOR0, 0, c);
      add_step(OP_RD, gfx_reg_pkg::REG_CONTROL, 0, model[0]);
      add_step(OP_RD, gfx_reg_pkg::REG_STATUS, 0, 0);
    end
    // sixteen writes fill the queue behind a busy rect draw
    add_step(OP_WR, gfx_reg_pkg::REG_CONTROL, 32'd1 << gfx_reg_pkg::CTRL_RECT, 0);
    model[0] = '0;
    for (k = 0; k < 17; k++)
    begin
      d = $random(seed);
      add_step((k == 16) ? OP_STALL : OP_WR, {(6'd2 + 6'(k % 7)), 2'b00}, d, 0);
      model[2 + (k % 7)] = d;
    end
    add_step(OP_DRAIN, 0, 0, 0);
    for (k = 0; k <= 8; k++)
      add_step(OP_RD, {k[5:0], 2'b00}, 0, model[k]);
    add_step(OP_FIELDS, 0, 0, 0);
    add_step(OP_TRIG, 0, 0, 2);
    add_step(OP_RD, 8'h3c, 0, 0);
    add_step(OP_ERR, 0, 1, 1);
    add_step(OP_ERR, 0, 0, 0);
    add_step(OP_ERR, 0, 2, 1);
    add_step(OP_ERR, 0, 3, 1);
    add_step(OP_ERR, 0, 0, 0);
  endtask

  // register contents once the write has been applied, triggers self-clear
  task automatic record_write(input logic [7:0] adr, input logic [31:0] data);
    if (adr == gfx_reg_pkg::REG_CONTROL)
      shadow[adr[7:2]] = data & ~TRIG_MASK;
    else
      shadow[adr[7:2]] = data;
  endtask

  task automatic check_fields();
    check_value("color_depth_o", shadow[0][1:0], color_depth_o);
    check_value("blending_enable_o", shadow[0][gfx_reg_pkg::CTRL_BLEND], blending_enable_o);
    check_value("clipping_enable_o", shadow[0][gfx_reg_pkg::CTRL_CLIP], clipping_enable_o);
    check_value("target_base_o", shadow[2][31:3], target_base_o);
    check_value("target_size_x_o", shadow[3][15:0], target_size_x_o);
    check_value("target_size_y_o", shadow[4][15:0], target_size_y_o);
    check_value("dest_x_o", shadow[5], dest_x_o);
    check_value("dest_y_o", shadow[6], dest_y_o);
    check_value("color0_o", shadow[7], color0_o);
    check_value("global_alpha_o", shadow[8][7:0], global_alpha_o);
  endtask

  task automatic pulse_pipeline_ack();
    @(negedge clk_i);
    pipeline_ack_i = 1'b1;
    @(negedge clk_i);
    pipeline_ack_i = 1'b0;
  endtask

  // a write to a full queue must wait until the pipeline frees an entry
  task automatic write_past_full(input logic [7:0] adr, input logic [31:0] data);
    @(negedge clk_i);
    cs_i  = 1'b1;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = 1'b1;
    sel_i = '1;
    adr_i = adr;
    dat_i = data;
    repeat (4)
    begin
      @(posedge clk_i);
      check_value("write to full queue ack", 0, ack_o);
    end
    pulse_pipeline_ack();
    @(posedge clk_i);
    while (ack_o !== 1'b1)
      @(posedge clk_i);
    @(negedge clk_i);
    cs_i  = 1'b0;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic run_step(input int i);
    logic [31:0] rdata;
    logic got_ack;
    logic got_err;
    string name;
    name = $sformatf("step %0d adr %h", i, adr_tab[i]);
    case (op_tab[i])
      OP_WR:
      begin
        bus_write(adr_tab[i], dat_tab[i]);
        record_write(adr_tab[i], dat_tab[i]);
      end
      OP_RD:
      begin
        bus_read(adr_tab[i], rdata);
        check_value(name, exp_tab[i], rdata);
      end
      OP_PART:
      begin
        bus_access(1'b1, 4'b0111, adr_tab[i], dat_tab[i], rdata, got_ack, got_err);
        check_value({name, " partial err"}, 1, got_err);
        check_value({name, " partial ack"}, 0, got_ack);
      end
      OP_DRAIN:
        wait_queue_empty();
      OP_ACK:
        pulse_pipeline_ack();
      OP_TRIG:
        check_value({name, " trigger cycles"}, exp_tab[i], trig_pulses[adr_tab[i]]);
      OP_FIELDS:
        check_fields();
      OP_STALL:
      begin
        write_past_full(adr_tab[i], dat_tab[i]);
        record_write(adr_tab[i], dat_tab[i]);
      end
      OP_ERR:
      begin
        @(negedge clk_i);
        writer_err_i = dat_tab[i][0];
        reader_err_i = dat_tab[i][1];
        @(negedge clk_i);
        check_value({name, " irq_o"}, exp_tab[i], irq_o);
      end
      default:
        check_value({name, " known step"}, 0, 1);
    endcase
  endtask

  initial
  begin
    seed           = 32'hd565;
    clk_i          = 1'b0;
    rst_i          = 1'b1;
    cs_i           = 1'b0;
    cyc_i          = 1'b0;
    stb_i          = 1'b0;
    we_i           = 1'b0;
    sel_i          = '0;
    adr_i          = '0;
    dat_i          = '0;
    pipeline_ack_i = 1'b0;
    writer_err_i   = 1'b0;
    reader_err_i   = 1'b0;
    for (int k = 0; k < 16; k++)
      shadow[k] = '0;
    shadow[8] = gfx_reg_pkg::ALPHA_RESET;
    build_table();
    limit = 40 * ntab + 200;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_value("irq_o after reset", 0, irq_o);
    check_value("rect_write_o after reset", 0, rect_write_o);
    check_value("line_write_o after reset", 0, line_write_o);
    check_value("triangle_write_o after reset", 0, triangle_write_o);
    check_value("ack_o after reset", 0, ack_o);
    check_value("err_o after reset", 0, err_o);
    for (int i = 0; i < ntab; i++)
      run_step(i);
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* project.f */
common/gfx_bus_pkg.sv
common/gfx_reg_pkg.sv
source/wb_bus_port.sv
source/cmd_fifo.sv
source/cmd_sequencer.sv
regfile/gfx_reg_file.sv
source/gfx_wbs_top.sv
+incdir+sim
sim/tb_gfx_wbs.sv

/* Makefile */
# Verilator flow for the graphics command front end

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_gfx_wbs
RTL_TOP   ?= gfx_wbs_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -sv --timing

.PHONY: all lint sim clean

all: sim

# RTL on its own, then together with the testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) \
		$(filter-out sim/%,$(shell grep -v '^+' $(FILELIST)))
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) \
		-f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
